/* mem_sched.f */
verilog/mem_sched_pkg.sv
verilog/sched_cmd_if.sv
verilog/request_fifo.sv
verilog/page_planner.sv
verilog/rw_cmd_queue.sv
verilog/dfi_phase_arbiter.sv
verilog/mem_sched_top.sv
dv/mem_sched_props.sv
dv/mem_sched_tb.sv

/* dv/mem_sched_tb.sv */
`timescale 1ns/1ps

module mem_sched_tb;
  import mem_sched_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int REQ_DEPTH    = 8;
  localparam int RW_DEPTH     = 4;
  localparam int WAIT_LIMIT   = 200;  // Cycles any single wait may take
  localparam int NUM_ROWS     = 21;

  typedef struct packed {
    logic [2:0] test_id;
    logic       write;
    bank_t      bank;
    page_t      page;
    col_t       col;
    logic       hold;                  // Keep dfi_init_done low while pushing
  } req_row_t;

  typedef struct packed {
    logic [DFI_CMD_W-1:0] cmd;
    bank_t                bank;
    addr_t                addr;
    data_t                wdata;
    logic [31:0]          need_rw;     // Accesses that must be seen before a close
  } exp_cmd_t;

  // Request table, one group of rows per test
  localparam req_row_t REQ_TABLE [NUM_ROWS] = '{
    // test  write  bank   page     col    hold
    '{3'd2, 1'b0, 3'd1, 12'h0a5, 6'd3,  1'b0},  // Closed bank
    '{3'd3, 1'b1, 3'd1, 12'h0a5, 6'd7,  1'b0},  // Hits on the open page
    '{3'd3, 1'b0, 3'd1, 12'h0a5, 6'd9,  1'b0},
    '{3'd4, 1'b0, 3'd1, 12'h123, 6'd1,  1'b0},  // Miss
    '{3'd4, 1'b1, 3'd5, 12'h300, 6'd2,  1'b0},
    '{3'd4, 1'b1, 3'd5, 12'h301, 6'd4,  1'b0},  // Miss behind a queued write
    '{3'd4, 1'b0, 3'd1, 12'h123, 6'd8,  1'b0},
    '{3'd5, 1'b0, 3'd5, 12'h301, 6'd30, 1'b1},  // Hits queue up while init is low
    '{3'd5, 1'b1, 3'd5, 12'h301, 6'd31, 1'b1},
    '{3'd5, 1'b0, 3'd5, 12'h302, 6'd32, 1'b1},  // Close has to wait for both
    '{3'd5, 1'b0, 3'd2, 12'h040, 6'd0,  1'b1},  // Pushed with init held low
    '{3'd5, 1'b1, 3'd2, 12'h040, 6'd5,  1'b1},
    '{3'd5, 1'b0, 3'd3, 12'h077, 6'd11, 1'b1},
    '{3'd5, 1'b1, 3'd2, 12'h041, 6'd6,  1'b1},
    '{3'd5, 1'b0, 3'd3, 12'h077, 6'd12, 1'b1},
    '{3'd5, 1'b1, 3'd2, 12'h041, 6'd13, 1'b1},
    '{3'd5, 1'b0, 3'd4, 12'h010, 6'd20, 1'b1},
    '{3'd5, 1'b1, 3'd3, 12'h078, 6'd21, 1'b1},
    '{3'd5, 1'b0, 3'd4, 12'h010, 6'd22, 1'b1},
    '{3'd5, 1'b1, 3'd2, 12'h040, 6'd23, 1'b1},
    '{3'd5, 1'b0, 3'd3, 12'h077, 6'd24, 1'b1}
  };

  logic                 clk;
  logic                 reset;
  logic                 req_valid;
  logic                 req_write;
  bank_t                req_bank;
  page_t                req_page;
  col_t                 req_col;
  data_t                req_wdata;
  logic                 req_ready;
  logic                 dfi_init_done;
  logic                 dfi_cs;
  logic                 dfi_phase;
  logic [DFI_CMD_W-1:0] dfi_cmd;
  bank_t                dfi_bank;
  addr_t                dfi_addr;
  data_t                dfi_wdata;

  logic [31:0]          lcg_state = 32'h5e7928cf;
  int                   errors    = 0;
  int                   tests_run = 0;
  int                   tests_bad = 0;
  int                   accepted  = 0;
  int                   rw_expected = 0;  // Accesses put into the model so far
  int                   rw_seen     = 0;  // Accesses seen on DFI so far
  int                   last_rw [NUM_BANKS];
  logic [NUM_BANKS-1:0] model_open = '0;  // Testbench copy of the open-page table
  page_t                model_page [NUM_BANKS];
  exp_cmd_t             exp_page_q [$];
  exp_cmd_t             exp_rw_q [$];

  mem_sched_top #(
    .REQ_FIFO_DEPTH(REQ_DEPTH),
    .RW_QUEUE_DEPTH(RW_DEPTH)
  ) dut (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_write(req_write), .req_bank(req_bank),
    .req_page(req_page), .req_col(req_col), .req_wdata(req_wdata),
    .req_ready(req_ready), .dfi_init_done(dfi_init_done),
    .dfi_cs(dfi_cs), .dfi_phase(dfi_phase), .dfi_cmd(dfi_cmd),
    .dfi_bank(dfi_bank), .dfi_addr(dfi_addr), .dfi_wdata(dfi_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic data_t next_rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    errors++;
  endtask

  // Expected commands for one accepted request
  task automatic model_accept(input req_row_t row, input data_t wd);
    exp_cmd_t e;
    if (!(model_open[row.bank] && (model_page[row.bank] == row.page)))
    begin
      if (model_open[row.bank])
      begin
        e = '{cmd: DFI_CMD_CLOSE, bank: row.bank, addr: model_page[row.bank],
              wdata: '0, need_rw: last_rw[row.bank]};
        exp_page_q.push_back(e);      // Old row goes first
      end
      e = '{cmd: DFI_CMD_OPEN, bank: row.bank, addr: row.page, wdata: '0, need_rw: 0};
      exp_page_q.push_back(e);
      model_open[row.bank] = 1'b1;
      model_page[row.bank] = row.page;
    end
    e = '{cmd: row.write ? DFI_CMD_WRITE : DFI_CMD_READ, bank: row.bank,
          addr: addr_t'(row.col), wdata: row.write ? wd : '0, need_rw: 0};
    exp_rw_q.push_back(e);
    rw_expected++;
    last_rw[row.bank] = rw_expected;
  endtask

  // Called on a falling edge; offers one request for a single cycle
  task automatic push_req(input req_row_t row, output bit taken);
    int    waited;
    data_t wd;
    waited = 0;
    taken  = 1'b0;
    while (!req_ready && !row.hold && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready)
    begin
      if (!row.hold)
        report_problem("timed out waiting for req_ready");
      return;
    end
    wd        = next_rand_word();
    req_valid = 1'b1;
    req_write = row.write;
    req_bank  = row.bank;
    req_page  = row.page;
    req_col   = row.col;
    req_wdata = wd;
    model_accept(row, wd);            // Ready was high, so this edge takes it
    @(negedge clk);
    req_valid = 1'b0;
    taken     = 1'b1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_page_q.size() + exp_rw_q.size()) != 0 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if ((exp_page_q.size() + exp_rw_q.size()) != 0)
      report_problem($sformatf("timed out with %0d page and %0d read/write commands missing",
                               exp_page_q.size(), exp_rw_q.size()));
    exp_page_q.delete();
    exp_rw_q.delete();
  endtask

  task automatic compare_cmd(input string kind, input exp_cmd_t e);
    if (dfi_cmd !== e.cmd || dfi_bank !== e.bank || dfi_addr !== e.addr ||
        dfi_wdata !== e.wdata)
      report_mismatch($sformatf("%s cmd %b bank %0d addr %h data %h, expected %b %0d %h %h",
                                kind, dfi_cmd, dfi_bank, dfi_addr, dfi_wdata,
                                e.cmd, e.bank, e.addr, e.wdata));
  endtask

  // --------------------------------------------------------------------------
  // DFI monitor, looks at each slot just before the edge that commits it
  // --------------------------------------------------------------------------
  initial
  begin
    exp_cmd_t e;
    forever
    begin
      @(posedge clk);
      #(CLK_PERIOD - 1);
      if (dfi_cs === 1'b0 && dfi_cmd !== DFI_CMD_NOP)
        report_mismatch($sformatf("dfi_cmd %b while dfi_cs is low", dfi_cmd));
      if (dfi_cs === 1'b1 && dfi_init_done !== 1'b1)
        report_mismatch("dfi_cs high while dfi_init_done is low");
      if (dfi_cs === 1'b1 && dfi_phase === 1'b0)
      begin
        if (exp_page_q.size() == 0)
          report_problem($sformatf("unexpected page command on bank %0d", dfi_bank));
        else
        begin
          e = exp_page_q.pop_front();
          compare_cmd("page", e);
          if (e.cmd == DFI_CMD_CLOSE && rw_seen < e.need_rw)
            report_mismatch($sformatf("close on bank %0d before its queued access", dfi_bank));
        end
      end
      else if (dfi_cs === 1'b1)
      begin
        if (exp_rw_q.size() == 0)
          report_problem($sformatf("unexpected read/write on bank %0d", dfi_bank));
        else
        begin
          e = exp_rw_q.pop_front();
          compare_cmd("read/write", e);
        end
        rw_seen++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic run_reset_test();
    int err_before;
    err_before = errors;
    for (int c = 0; c < RESET_CYCLES; c++)
    begin
      @(negedge clk);
      if (req_ready !== 1'b0 || dfi_cs !== 1'b0 || dfi_phase !== 1'b0)
        report_mismatch("req_ready, dfi_cs or dfi_phase not low during reset");
    end
    reset = 1'b0;
    if (req_ready !== 1'b0)
      report_mismatch("req_ready high right after reset");
    @(negedge clk);
    if (req_ready !== 1'b1)
      report_mismatch("req_ready did not rise on the first cycle after reset");
    if (dfi_cs !== 1'b0 || dfi_phase !== 1'b0)
      report_mismatch("dfi_cs or dfi_phase high after reset with init low");
    tests_run++;
    if (errors != err_before)
      tests_bad++;
    $display("test 1 reset        %s", (errors == err_before) ? "ok" : "had errors");
  endtask

  task automatic run_test(input int id, input string name);
    int err_before;
    bit holding;
    bit taken;
    bit stopped;
    err_before = errors;
    holding    = 1'b0;
    stopped    = 1'b0;
    accepted   = 0;
    for (int i = 0; i < NUM_ROWS; i++)
      if (REQ_TABLE[i].test_id == id)
        holding |= REQ_TABLE[i].hold;
    @(negedge clk);
    dfi_init_done = !holding;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (REQ_TABLE[i].test_id == id && !stopped)
      begin
        push_req(REQ_TABLE[i], taken);
        if (taken)
          accepted++;
        else
          stopped = 1'b1;             // Back-pressure reached, or a timeout
      end
    end
    if (holding)
    begin
      if (req_ready)
        report_problem("req_ready never dropped while init was held low");
      // Hits may still move on into the read/write queue while the FIFO fills
      if (accepted < REQ_DEPTH - 2 || accepted > REQ_DEPTH + RW_DEPTH)
        report_mismatch($sformatf("%0d requests accepted before back-pressure", accepted));
      dfi_init_done = 1'b1;           // Release and let both queues drain
    end
    wait_drain();
    tests_run++;
    if (errors != err_before)
      tests_bad++;
    $display("test %0d %-12s %s, %0d requests accepted", id, name,
             (errors == err_before) ? "ok" : "had errors", accepted);
  endtask

  initial
  begin
    reset         = 1'b1;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_bank      = '0;
    req_page      = '0;
    req_col       = '0;
    req_wdata     = '0;
    dfi_init_done = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++)
      last_rw[b] = 0;
    run_reset_test();
    run_test(2, "closed bank");
    run_test(3, "page hit");
    run_test(4, "page miss");
    run_test(5, "backpressure");
    repeat (20) @(negedge clk);       // Idle tail, any stray command is flagged
    $display("tests %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_bad, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* dv/mem_sched_props.sv */
`timescale 1ns/1ps

module mem_sched_props (
  input logic                                clk,
  input logic                                reset,
  input logic                                dfi_init_done,
  input logic                                req_ready,
  input logic                                dfi_cs,
  input logic                                dfi_phase,
  input logic [mem_sched_pkg::DFI_CMD_W-1:0] dfi_cmd
);
  import mem_sched_pkg::*;

  // No slot is granted before the PHY reports init done
  cs_needs_init: assert property (@(posedge clk) disable iff (reset)
    !dfi_init_done |-> !dfi_cs)
    else $error("dfi_cs high while dfi_init_done is low");

  // Quiet bus carries NOP
  nop_when_idle: assert property (@(posedge clk) disable iff (reset)
    !dfi_cs |-> (dfi_cmd == DFI_CMD_NOP))
    else $error("dfi_cmd not NOP while dfi_cs is low");

  // Page and read/write phases alternate once init is done
  phase_toggles: assert property (@(posedge clk) disable iff (reset)
    ($past(dfi_init_done) && !$past(reset)) |-> (dfi_phase != $past(dfi_phase)))
    else $error("dfi_phase did not toggle while init is done");

  // Ready is held off through reset
  ready_low_in_reset: assert property (@(posedge clk)
    (reset ##1 reset) |-> !req_ready)
    else $error("req_ready high during reset");

endmodule

bind mem_sched_top mem_sched_props props (.*);

/* verilog/mem_sched_top.sv */
`timescale 1ns/1ps

module mem_sched_top #(
  parameter int REQ_FIFO_DEPTH = 8,
  parameter int RW_QUEUE_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  // Request port
  input  logic                                req_valid,
  input  logic                                req_write,
  input  mem_sched_pkg::bank_t                req_bank,
  input  mem_sched_pkg::page_t                req_page,
  input  mem_sched_pkg::col_t                 req_col,
  input  mem_sched_pkg::data_t                req_wdata,
  output logic                                req_ready,
  // DFI
  input  logic                                dfi_init_done,
  output logic                                dfi_cs,
  output logic                                dfi_phase,
  output logic [mem_sched_pkg::DFI_CMD_W-1:0] dfi_cmd,
  output mem_sched_pkg::bank_t                dfi_bank,
  output mem_sched_pkg::addr_t                dfi_addr,
  output mem_sched_pkg::data_t                dfi_wdata
);
  import mem_sched_pkg::*;

  // FIFO head toward the planner
  logic                 head_valid;
  logic                 head_write;
  bank_t                head_bank;
  page_t                head_page;
  col_t                 head_col;
  data_t                head_wdata;
  logic                 head_pop;
  // Planner toward the read/write queue
  logic                 q_push;
  logic                 q_push_write;
  bank_t                q_push_bank;
  col_t                 q_push_col;
  data_t                q_push_wdata;
  logic                 rw_full;
  logic [NUM_BANKS-1:0] pending_banks;

  sched_cmd_if page_cmd_bus ();
  sched_cmd_if rw_cmd_bus ();

  request_fifo #(.REQ_FIFO_DEPTH(REQ_FIFO_DEPTH)) u_request_fifo (
    .clk(clk), .reset(reset),
    .push(req_valid), .push_write(req_write), .push_bank(req_bank),
    .push_page(req_page), .push_col(req_col), .push_wdata(req_wdata),
    .ready(req_ready),
    .head_valid(head_valid), .head_write(head_write), .head_bank(head_bank),
    .head_page(head_page), .head_col(head_col), .head_wdata(head_wdata),
    .pop(head_pop)
  );

  page_planner u_page_planner (
    .clk(clk), .reset(reset),
    .head_valid(head_valid), .head_write(head_write), .head_bank(head_bank),
    .head_page(head_page), .head_col(head_col), .head_wdata(head_wdata),
    .pop(head_pop), .page_cmd(page_cmd_bus.src),
    .push(q_push), .push_write(q_push_write), .push_bank(q_push_bank),
    .push_col(q_push_col), .push_wdata(q_push_wdata),
    .rw_full(rw_full), .pending_banks(pending_banks)
  );

  rw_cmd_queue #(.RW_QUEUE_DEPTH(RW_QUEUE_DEPTH)) u_rw_cmd_queue (
    .clk(clk), .reset(reset),
    .push(q_push), .push_write(q_push_write), .push_bank(q_push_bank),
    .push_col(q_push_col), .push_wdata(q_push_wdata),
    .full(rw_full), .pending_banks(pending_banks), .rw_cmd(rw_cmd_bus.src)
  );

  dfi_phase_arbiter u_dfi_phase_arbiter (
    .clk(clk), .reset(reset), .dfi_init_done(dfi_init_done),
    .page_cmd(page_cmd_bus.arb), .rw_cmd(rw_cmd_bus.arb),
    .dfi_cs(dfi_cs), .dfi_phase(dfi_phase), .dfi_cmd(dfi_cmd),
    .dfi_bank(dfi_bank), .dfi_addr(dfi_addr), .dfi_wdata(dfi_wdata)
  );

endmodule

/* verilog/dfi_phase_arbiter.sv */
`timescale 1ns/1ps

module dfi_phase_arbiter (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  dfi_init_done,
  sched_cmd_if.arb                              page_cmd,
  sched_cmd_if.arb                              rw_cmd,
  output logic                                  dfi_cs,
  output logic                                  dfi_phase,
  output logic [mem_sched_pkg::DFI_CMD_W-1:0]   dfi_cmd,
  output mem_sched_pkg::bank_t                  dfi_bank,
  output mem_sched_pkg::addr_t                  dfi_addr,
  output mem_sched_pkg::data_t                  dfi_wdata
);
  import mem_sched_pkg::*;

  logic    phase;        // 0 page phase, 1 read/write phase
  logic    page_slot;
  logic    rw_slot;
  logic    grant;
  cmd_op_e sel_op;
  bank_t   sel_bank;
  addr_t   sel_addr;
  data_t   sel_wdata;

  // Map a command to its bus code, the phase tells the DRAM which table applies
  function automatic logic [DFI_CMD_W-1:0] encode_op(input cmd_op_e op);
    case (op)
      OP_CLOSE: return DFI_CMD_CLOSE;
      OP_OPEN:  return DFI_CMD_OPEN;
      OP_READ:  return DFI_CMD_READ;
      OP_WRITE: return DFI_CMD_WRITE;
      default:  return DFI_CMD_NOP;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Phase toggle, parked in the page phase until init is done
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || !dfi_init_done)
      phase <= 1'b0;
    else
      phase <= ~phase;
  end

  assign dfi_phase = phase;

  // One slot per cycle, owned by the source of this phase
  assign page_slot      = dfi_init_done & ~phase;
  assign rw_slot        = dfi_init_done & phase;
  assign page_cmd.ready = page_slot;
  assign rw_cmd.ready   = rw_slot;
  assign grant          = (page_slot & page_cmd.valid) | (rw_slot & rw_cmd.valid);

  // Source mux by phase
  assign sel_op    = phase ? rw_cmd.op    : page_cmd.op;
  assign sel_bank  = phase ? rw_cmd.bank  : page_cmd.bank;
  assign sel_addr  = phase ? rw_cmd.addr  : page_cmd.addr;
  assign sel_wdata = phase ? rw_cmd.wdata : page_cmd.wdata;

  // --------------------------------------------------------------------------
  // Bus drive, quiet unless a command is granted
  // --------------------------------------------------------------------------
  always_comb
  begin
    dfi_cs    = grant;
    dfi_cmd   = grant ? encode_op(sel_op) : DFI_CMD_NOP;
    dfi_bank  = grant ? sel_bank : '0;
    dfi_addr  = grant ? sel_addr : '0;
    dfi_wdata = (grant && (sel_op == OP_WRITE)) ? sel_wdata : '0;  // Data rides with the write
  end

endmodule

/* verilog/rw_cmd_queue.sv */
`timescale 1ns/1ps

module rw_cmd_queue #(
  parameter int RW_QUEUE_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                push,
  input  logic                                push_write,
  input  mem_sched_pkg::bank_t                push_bank,
  input  mem_sched_pkg::col_t                 push_col,
  input  mem_sched_pkg::data_t                push_wdata,
  output logic                                full,
  output logic [mem_sched_pkg::NUM_BANKS-1:0] pending_banks,
  sched_cmd_if.src                            rw_cmd
);
  import mem_sched_pkg::*;

  localparam int PTR_W = (RW_QUEUE_DEPTH > 1) ? $clog2(RW_QUEUE_DEPTH) : 1;

  logic [RW_QUEUE_DEPTH-1:0] slot_busy;           // Entry holds an unissued command
  logic                      q_write [RW_QUEUE_DEPTH];
  bank_t                     q_bank  [RW_QUEUE_DEPTH];
  col_t                      q_col   [RW_QUEUE_DEPTH];
  data_t                     q_wdata [RW_QUEUE_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic                      wr_en;
  logic                      rd_en;

  assign full  = slot_busy[wr_ptr];               // Next slot still in use
  assign wr_en = push & ~full;
  assign rd_en = rw_cmd.valid & rw_cmd.ready;     // Issued on the DFI bus

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      slot_busy <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        slot_busy[wr_ptr] <= 1'b1;
        wr_ptr <= (wr_ptr == PTR_W'(RW_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        slot_busy[rd_ptr] <= 1'b0;
        rd_ptr <= (rd_ptr == PTR_W'(RW_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      q_write[wr_ptr] <= push_write;
      q_bank[wr_ptr]  <= push_bank;
      q_col[wr_ptr]   <= push_col;
      q_wdata[wr_ptr] <= push_wdata;
    end
  end

  // Banks with a queued access, the planner may not close these
  always_comb
  begin
    pending_banks = '0;
    for (int i = 0; i < RW_QUEUE_DEPTH; i++)
      if (slot_busy[i])
        pending_banks[q_bank[i]] = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Head offer, one cycle after its push
  // --------------------------------------------------------------------------
  assign rw_cmd.valid = slot_busy[rd_ptr];
  assign rw_cmd.op    = q_write[rd_ptr] ? OP_WRITE : OP_READ;
  assign rw_cmd.bank  = q_bank[rd_ptr];
  assign rw_cmd.addr  = {{(ADDR_W - COL_W){1'b0}}, q_col[rd_ptr]};  // Column in low bits
  assign rw_cmd.wdata = q_write[rd_ptr] ? q_wdata[rd_ptr] : '0;

endmodule

/* verilog/page_planner.sv */
`timescale 1ns/1ps

module page_planner (
  input  logic                                   clk,
  input  logic                                   reset,
  // Request FIFO head
  input  logic                                   head_valid,
  input  logic                                   head_write,
  input  mem_sched_pkg::bank_t                   head_bank,
  input  mem_sched_pkg::page_t                   head_page,
  input  mem_sched_pkg::col_t                    head_col,
  input  mem_sched_pkg::data_t                   head_wdata,
  output logic                                   pop,
  // Page commands toward the arbiter
  sched_cmd_if.src                               page_cmd,
  // Read/write queue
  output logic                                   push,
  output logic                                   push_write,
  output mem_sched_pkg::bank_t                   push_bank,
  output mem_sched_pkg::col_t                    push_col,
  output mem_sched_pkg::data_t                   push_wdata,
  input  logic                                   rw_full,
  input  logic [mem_sched_pkg::NUM_BANKS-1:0]    pending_banks
);
  import mem_sched_pkg::*;

  planner_state_e         state;
  planner_state_e         state_nxt;
  logic [NUM_BANKS-1:0]   open_valid;               // Bank has a page open
  page_t                  open_page [NUM_BANKS];    // Which page, valid only with open_valid
  logic                   page_hit;
  logic                   page_grant;

  assign page_hit   = open_valid[head_bank] && (open_page[head_bank] == head_page);
  assign page_grant = page_cmd.valid & page_cmd.ready;   // Arbiter took the page command

  // Head fields go to the queue unchanged
  assign push_write = head_write;
  assign push_bank  = head_bank;
  assign push_col   = head_col;
  assign push_wdata = head_wdata;

  // --------------------------------------------------------------------------
  // Next state and command offer
  // --------------------------------------------------------------------------
  always_comb
  begin
    state_nxt      = state;
    page_cmd.valid = 1'b0;
    page_cmd.op    = OP_OPEN;
    page_cmd.bank  = head_bank;
    page_cmd.addr  = head_page;           // New page for an open
    page_cmd.wdata = '0;                  // Page commands carry no data
    push           = 1'b0;
    pop            = 1'b0;
    case (state)
      PL_IDLE:
      begin
        if (head_valid)
        begin
          if (page_hit)
            state_nxt = PL_FORWARD;       // Row already open
          else if (open_valid[head_bank])
            state_nxt = PL_CLOSE;         // Other row open in this bank
          else
            state_nxt = PL_OPEN;          // Bank closed
        end
      end
      PL_CLOSE:
      begin
        // Hold off until no queued read/write still targets the old row
        page_cmd.valid = !pending_banks[head_bank];
        page_cmd.op    = OP_CLOSE;
        page_cmd.addr  = open_page[head_bank];
        if (page_grant)
          state_nxt = PL_OPEN;
      end
      PL_OPEN:
      begin
        page_cmd.valid = 1'b1;
        if (page_grant)
          state_nxt = PL_FORWARD;
      end
      PL_FORWARD:
      begin
        if (!rw_full)
        begin
          push      = 1'b1;               // Hand the access to the queue
          pop       = 1'b1;               // and retire the request
          state_nxt = PL_IDLE;
        end
      end
      default: state_nxt = PL_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= PL_IDLE;
    else
      state <= state_nxt;
  end

  // --------------------------------------------------------------------------
  // Open-page table, updated when a page command is granted
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      open_valid <= '0;                   // All banks closed
    else if (page_grant)
      open_valid[head_bank] <= (page_cmd.op == OP_OPEN);
  end

  always_ff @(posedge clk)
  begin
    if (page_grant && (page_cmd.op == OP_OPEN))
      open_page[head_bank] <= head_page;
  end

endmodule

/* verilog/request_fifo.sv */
`timescale 1ns/1ps

module request_fifo #(
  parameter int REQ_FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,         // Raw req_valid from the port
  input  logic                 push_write,
  input  mem_sched_pkg::bank_t push_bank,
  input  mem_sched_pkg::page_t push_page,
  input  mem_sched_pkg::col_t  push_col,
  input  mem_sched_pkg::data_t push_wdata,
  output logic                 ready,
  output logic                 head_valid,
  output logic                 head_write,
  output mem_sched_pkg::bank_t head_bank,
  output mem_sched_pkg::page_t head_page,
  output mem_sched_pkg::col_t  head_col,
  output mem_sched_pkg::data_t head_wdata,
  input  logic                 pop
);
  import mem_sched_pkg::*;

  localparam int PTR_W       = (REQ_FIFO_DEPTH > 1) ? $clog2(REQ_FIFO_DEPTH) : 1;
  localparam int CNT_W       = $clog2(REQ_FIFO_DEPTH + 1);
  localparam int ALMOST_FULL = REQ_FIFO_DEPTH - 2;  // Leaves room for the lag of ready

  logic             mem_write [REQ_FIFO_DEPTH];
  bank_t            mem_bank  [REQ_FIFO_DEPTH];
  page_t            mem_page  [REQ_FIFO_DEPTH];
  col_t             mem_col   [REQ_FIFO_DEPTH];
  data_t            mem_wdata [REQ_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  assign wr_en = push & ready;        // Accepted request, valid and ready together
  assign rd_en = pop & head_valid;

  // --------------------------------------------------------------------------
  // Pointers, occupancy and registered ready
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ready  <= 1'b0;                 // Rises on the first cycle after reset
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Idle or push with pop
      endcase
      ready <= (count < CNT_W'(ALMOST_FULL));
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem_write[wr_ptr] <= push_write;
      mem_bank[wr_ptr]  <= push_bank;
      mem_page[wr_ptr]  <= push_page;
      mem_col[wr_ptr]   <= push_col;
      mem_wdata[wr_ptr] <= push_wdata;
    end
  end

  // Head is visible the cycle after the push
  assign head_valid = (count != '0);
  assign head_write = mem_write[rd_ptr];
  assign head_bank  = mem_bank[rd_ptr];
  assign head_page  = mem_page[rd_ptr];
  assign head_col   = mem_col[rd_ptr];
  assign head_wdata = mem_wdata[rd_ptr];

endmodule

/* verilog/sched_cmd_if.sv */
`timescale 1ns/1ps

// One command source offering a command to the DFI phase arbiter
interface sched_cmd_if;
  import mem_sched_pkg::*;

  logic    valid;  // Source has a command, held until ready
  logic    ready;  // Arbiter slot for this source
  cmd_op_e op;
  bank_t   bank;
  addr_t   addr;   // Page or zero-extended column
  data_t   wdata;  // Only meaningful with OP_WRITE

  // Command source side
  modport src (
    output valid, op, bank, addr, wdata,
    input  ready
  );

  // Arbiter side
  modport arb (
    input  valid, op, bank, addr, wdata,
    output ready
  );

endinterface

/* verilog/mem_sched_pkg.sv */
package mem_sched_pkg;

  // --------------------------------------------------------------------------
  // Geometry of one channel
  // --------------------------------------------------------------------------
  localparam int NUM_BANKS = 8;
  localparam int BANK_W    = 3;   // Bank select
  localparam int PAGE_W    = 12;  // Row address
  localparam int COL_W     = 6;   // Cache line within a page
  localparam int ADDR_W    = 12;  // Shared row/column bus on DFI
  localparam int DATA_W    = 32;  // One write word per command
  localparam int DFI_CMD_W = 2;

  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [PAGE_W-1:0] page_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Command kinds carried between the sources and the arbiter
  typedef enum logic [1:0] {
    OP_OPEN,
    OP_CLOSE,
    OP_READ,
    OP_WRITE
  } cmd_op_e;

  // Planner steps for one head request
  typedef enum logic [1:0] {
    PL_IDLE,
    PL_CLOSE,
    PL_OPEN,
    PL_FORWARD
  } planner_state_e;

  // --------------------------------------------------------------------------
  // DFI command codes, meaning depends on dfi_phase
  // --------------------------------------------------------------------------
  localparam logic [DFI_CMD_W-1:0] DFI_CMD_NOP   = 2'b00;
  // Page phase
  localparam logic [DFI_CMD_W-1:0] DFI_CMD_CLOSE = 2'b10;
  localparam logic [DFI_CMD_W-1:0] DFI_CMD_OPEN  = 2'b11;
  // Read/write phase
  localparam logic [DFI_CMD_W-1:0] DFI_CMD_READ  = 2'b10;
  localparam logic [DFI_CMD_W-1:0] DFI_CMD_WRITE = 2'b11;

endpackage
